// File: Makefile
TOP = tb_cpu_core

sim:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f compile.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q '\*\*\* FAILED \*\*\*' sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' sim.log || { echo "simulation did not pass"; exit 1; }

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: compile.f
+incdir+include
rtl/isa_pkg.sv
rtl/core_pkg.sv
rtl/fetch_stage.sv
rtl/instr_decoder.sv
rtl/issue_window.sv
rtl/reg_file.sv
rtl/alu_unit.sv
rtl/mem_unit.sv
rtl/cpu_core.sv
tb/cpu_core_chk.sv
tb/tb_cpu_core.sv

// File: include/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// half-word pc, one bit below the instruction word address
`define CORE_PC_W 14
`define CORE_IADDR_W 13
`define CORE_DADDR_W 17

`define CORE_XLEN 32
`define CORE_NREG 32
`define CORE_REG_W 5

// wait window entries
`define CORE_WIN_DEPTH 3

`endif

// File: rtl/alu_unit.sv
`timescale 1ns/1ps
`include "core_config.svh"

module alu_unit (
	input  logic              clk,
	input  logic              rstn,
	input  core_pkg::issue_t  i_issue,
	output core_pkg::wb_t     o_wb
);

	logic [`CORE_XLEN-1:0] result;

	always_comb begin
		case (i_issue.uop.op)
			isa_pkg::OP_ADD:  result = i_issue.rs_val + i_issue.rt_val;
			isa_pkg::OP_SUB:  result = i_issue.rs_val - i_issue.rt_val;
			isa_pkg::OP_AND:  result = i_issue.rs_val & i_issue.rt_val;
			isa_pkg::OP_OR:   result = i_issue.rs_val | i_issue.rt_val;
			isa_pkg::OP_ADDI: result = i_issue.rs_val + i_issue.uop.imm;
			default:          result = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		o_wb.rd <= i_issue.uop.rd;
		o_wb.data <= result;
		// r0 targets produce no writeback
		if (!rstn)
			o_wb.valid <= 1'b0;
		else
			o_wb.valid <= i_issue.valid && i_issue.uop.writes_rd;
	end

endmodule

// File: rtl/core_pkg.sv
`include "core_config.svh"

package core_pkg;

	typedef enum logic {
		FS_BEGIN  = 1'b0,
		FS_NORMAL = 1'b1
	} fetch_state_e;

	typedef enum logic [1:0] {
		UNIT_NONE = 2'd0,
		UNIT_ALU  = 2'd1,
		UNIT_MEM  = 2'd2
	} unit_e;

	// flags mark real dependences only, register 0 never sets one
	typedef struct packed {
		logic [`CORE_PC_W-1:0]  pc;
		isa_pkg::op_e           op;
		logic [`CORE_REG_W-1:0] rs;
		logic [`CORE_REG_W-1:0] rt;
		logic [`CORE_REG_W-1:0] rd;
		logic [`CORE_XLEN-1:0]  imm;
		unit_e                  unit;
		logic                   uses_rs;
		logic                   uses_rt;
		logic                   writes_rd;
	} uop_t;

	// instr[0] is the upper half of the fetched word
	typedef struct packed {
		isa_pkg::instr_t [1:0] instr;
		logic [1:0]            valid;
		logic [`CORE_PC_W-1:0] pc;
	} fetch_pair_t;

	typedef struct packed {
		logic                  valid;
		uop_t                  uop;
		logic [`CORE_XLEN-1:0] rs_val;
		logic [`CORE_XLEN-1:0] rt_val;
	} issue_t;

	typedef struct packed {
		logic                   valid;
		logic [`CORE_REG_W-1:0] rd;
		logic [`CORE_XLEN-1:0]  data;
	} wb_t;

endpackage

// File: rtl/cpu_core.sv
`timescale 1ns/1ps
`include "core_config.svh"

module cpu_core (
	input  logic                      clk,
	input  logic                      rstn,
	output logic [`CORE_IADDR_W-1:0]  o_iaddr,
	output logic                      o_ien,
	input  logic [2*`CORE_XLEN-1:0]   i_idata,
	output logic [`CORE_DADDR_W-1:0]  o_daddr,
	output logic [`CORE_XLEN-1:0]     o_dwdata,
	input  logic [`CORE_XLEN-1:0]     i_drdata,
	output logic                      o_den,
	output logic                      o_dwe
);

	core_pkg::fetch_pair_t pair;
	logic win_busy;
	core_pkg::uop_t dec_uop [2];
	logic [1:0] dec_valid;
	logic [`CORE_WIN_DEPTH-1:0][`CORE_REG_W-1:0] rs_idx;
	logic [`CORE_WIN_DEPTH-1:0][`CORE_REG_W-1:0] rt_idx;
	logic [`CORE_WIN_DEPTH-1:0][`CORE_XLEN-1:0] rs_val;
	logic [`CORE_WIN_DEPTH-1:0][`CORE_XLEN-1:0] rt_val;
	core_pkg::issue_t alu_issue;
	core_pkg::issue_t mem_issue;
	core_pkg::wb_t alu_wb;
	core_pkg::wb_t mem_wb;

	// instruction memory is always read
	assign o_ien = 1'b1;

	fetch_stage u_fetch (
		.clk        (clk),
		.rstn       (rstn),
		.i_idata    (i_idata),
		.i_win_busy (win_busy),
		.o_iaddr    (o_iaddr),
		.o_pair     (pair)
	);

	for (genvar k = 0; k < 2; k++) begin : g_dec
		instr_decoder u_dec (
			.i_instr (pair.instr[k]),
			.i_valid (pair.valid[k]),
			.i_pc    ({pair.pc[`CORE_PC_W-1:1], 1'(k)}),
			.o_uop   (dec_uop[k]),
			.o_valid (dec_valid[k])
		);
	end

	issue_window u_win (
		.clk         (clk),
		.rstn        (rstn),
		.i_uop0      (dec_uop[0]),
		.i_valid0    (dec_valid[0]),
		.i_uop1      (dec_uop[1]),
		.i_valid1    (dec_valid[1]),
		.i_rs_val    (rs_val),
		.i_rt_val    (rt_val),
		.i_alu_wb    (alu_wb),
		.i_mem_wb    (mem_wb),
		.o_rs_idx    (rs_idx),
		.o_rt_idx    (rt_idx),
		.o_alu_issue (alu_issue),
		.o_mem_issue (mem_issue),
		.o_busy      (win_busy)
	);

	reg_file u_rf (
		.clk      (clk),
		.rstn     (rstn),
		.i_rs_idx (rs_idx),
		.i_rt_idx (rt_idx),
		.i_alu_wb (alu_wb),
		.i_mem_wb (mem_wb),
		.o_rs_val (rs_val),
		.o_rt_val (rt_val)
	);

	alu_unit u_alu (
		.clk     (clk),
		.rstn    (rstn),
		.i_issue (alu_issue),
		.o_wb    (alu_wb)
	);

	mem_unit u_mem (
		.clk      (clk),
		.rstn     (rstn),
		.i_issue  (mem_issue),
		.i_drdata (i_drdata),
		.o_daddr  (o_daddr),
		.o_dwdata (o_dwdata),
		.o_den    (o_den),
		.o_dwe    (o_dwe),
		.o_wb     (mem_wb)
	);

endmodule

// File: rtl/fetch_stage.sv
`timescale 1ns/1ps
`include "core_config.svh"

module fetch_stage (
	input  logic                      clk,
	input  logic                      rstn,
	input  logic [2*`CORE_XLEN-1:0]   i_idata,
	input  logic                      i_win_busy,
	output logic [`CORE_IADDR_W-1:0]  o_iaddr,
	output core_pkg::fetch_pair_t     o_pair
);

	logic [`CORE_PC_W-1:0] pc;
	logic [`CORE_PC_W-1:0] if_pc;
	core_pkg::fetch_state_e state;
	logic was_busy;
	core_pkg::fetch_pair_t hold;
	core_pkg::fetch_pair_t fetched;

	assign o_iaddr = pc[`CORE_PC_W-1:1];

	// data arriving after a busy cycle belongs to a stale address
	always_comb begin
		fetched.instr[0] = isa_pkg::instr_t'(i_idata[2*`CORE_XLEN-1:`CORE_XLEN]);
		fetched.instr[1] = isa_pkg::instr_t'(i_idata[`CORE_XLEN-1:0]);
		fetched.valid = {2{~was_busy}};
		fetched.pc = if_pc;
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			pc <= '0;
			if_pc <= '0;
			state <= core_pkg::FS_BEGIN;
			was_busy <= 1'b0;
			hold.valid <= '0;
			o_pair.valid <= '0;
		end else if (state == core_pkg::FS_BEGIN) begin
			pc <= {pc[`CORE_PC_W-1:1] + 1'b1, 1'b0};
			state <= core_pkg::FS_NORMAL;
		end else begin
			if_pc <= pc;
			was_busy <= i_win_busy;
			if (i_win_busy) begin
				// park the pair that met the rising edge of busy
				if (!was_busy)
					hold <= fetched;
			end else begin
				pc <= {pc[`CORE_PC_W-1:1] + 1'b1, 1'b0};
				o_pair <= was_busy ? hold : fetched;
			end
		end
	end

endmodule

// File: rtl/instr_decoder.sv
`timescale 1ns/1ps
`include "core_config.svh"

module instr_decoder (
	input  isa_pkg::instr_t        i_instr,
	input  logic                   i_valid,
	input  logic [`CORE_PC_W-1:0]  i_pc,
	output core_pkg::uop_t         o_uop,
	output logic                   o_valid
);

	core_pkg::unit_e unit;
	logic uses_rt;
	logic writes_rd;

	always_comb begin
		unit = core_pkg::UNIT_NONE;
		uses_rt = 1'b0;
		writes_rd = 1'b0;
		case (i_instr.opcode)
			isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_AND, isa_pkg::OP_OR: begin
				unit = core_pkg::UNIT_ALU;
				uses_rt = 1'b1;
				writes_rd = 1'b1;
			end
			isa_pkg::OP_ADDI: begin
				unit = core_pkg::UNIT_ALU;
				writes_rd = 1'b1;
			end
			isa_pkg::OP_LW: begin
				unit = core_pkg::UNIT_MEM;
				writes_rd = 1'b1;
			end
			isa_pkg::OP_SW: begin
				unit = core_pkg::UNIT_MEM;
				uses_rt = 1'b1;
			end
			default: unit = core_pkg::UNIT_NONE;
		endcase
	end

	always_comb begin
		o_uop.pc = i_pc;
		o_uop.op = i_instr.opcode;
		o_uop.rs = i_instr.rs;
		o_uop.rt = i_instr.lo.r.rt;
		o_uop.rd = i_instr.rd;
		o_uop.imm = {{(`CORE_XLEN-16){i_instr.lo.imm[15]}}, i_instr.lo.imm};
		o_uop.unit = unit;
		// r0 carries no dependence
		o_uop.uses_rs = (unit != core_pkg::UNIT_NONE) && (i_instr.rs != '0);
		o_uop.uses_rt = uses_rt && (i_instr.lo.r.rt != '0);
		o_uop.writes_rd = writes_rd && (i_instr.rd != '0);
	end

	// nop and unknown opcodes never enter the window
	assign o_valid = i_valid && (unit != core_pkg::UNIT_NONE);

endmodule

// File: rtl/isa_pkg.sv
`include "core_config.svh"

package isa_pkg;

	typedef enum logic [5:0] {
		OP_NOP  = 6'd0,
		OP_ADD  = 6'd1,
		OP_SUB  = 6'd2,
		OP_AND  = 6'd3,
		OP_OR   = 6'd4,
		OP_ADDI = 6'd5,
		OP_LW   = 6'd6,
		OP_SW   = 6'd7
	} op_e;

	// register form of the low half
	typedef struct packed {
		logic [`CORE_REG_W-1:0] rt;
		logic [10:0]            spare;
	} instr_rlo_t;

	// rt sits in the top bits of the immediate
	typedef union packed {
		logic [15:0] imm;
		instr_rlo_t  r;
	} instr_lo_t;

	typedef struct packed {
		op_e                    opcode;
		logic [`CORE_REG_W-1:0] rd;
		logic [`CORE_REG_W-1:0] rs;
		instr_lo_t              lo;
	} instr_t;

endpackage

// File: rtl/issue_window.sv
`timescale 1ns/1ps
`include "core_config.svh"

module issue_window (
	input  logic                                         clk,
	input  logic                                         rstn,
	input  core_pkg::uop_t                               i_uop0,
	input  logic                                         i_valid0,
	input  core_pkg::uop_t                               i_uop1,
	input  logic                                         i_valid1,
	input  logic [`CORE_WIN_DEPTH-1:0][`CORE_XLEN-1:0]   i_rs_val,
	input  logic [`CORE_WIN_DEPTH-1:0][`CORE_XLEN-1:0]   i_rt_val,
	input  core_pkg::wb_t                                i_alu_wb,
	input  core_pkg::wb_t                                i_mem_wb,
	output logic [`CORE_WIN_DEPTH-1:0][`CORE_REG_W-1:0]  o_rs_idx,
	output logic [`CORE_WIN_DEPTH-1:0][`CORE_REG_W-1:0]  o_rt_idx,
	output core_pkg::issue_t                             o_alu_issue,
	output core_pkg::issue_t                             o_mem_issue,
	output logic                                         o_busy
);

	localparam int DEPTH = `CORE_WIN_DEPTH;

	core_pkg::uop_t win_uop [DEPTH];
	logic [DEPTH-1:0] win_v;
	logic [`CORE_NREG-1:0] pending;
	logic [`CORE_NREG-1:0] src_mask [DEPTH];
	logic [`CORE_NREG-1:0] dst_mask [DEPTH];
	logic [`CORE_NREG-1:0] older_wr;
	logic [`CORE_NREG-1:0] older_rd;
	logic older_mem;
	logic [DEPTH-1:0] ready;
	logic [DEPTH-1:0] mem_first;
	logic [DEPTH-1:0] alu_sel;
	logic [DEPTH-1:0] mem_sel;
	logic [DEPTH-1:0] remain;
	logic [`CORE_NREG-1:0] set_mask;
	logic [`CORE_NREG-1:0] clr_mask;
	core_pkg::uop_t nxt_uop [DEPTH];
	logic [DEPTH-1:0] nxt_v;
	logic [1:0] fill;
	core_pkg::issue_t alu_nxt;
	core_pkg::issue_t mem_nxt;

	function automatic core_pkg::issue_t pick(input logic [DEPTH-1:0] sel);
		core_pkg::issue_t r;
		r = '0;
		for (int i = 0; i < DEPTH; i++) begin
			if (sel[i]) begin
				r.valid = 1'b1;
				r.uop = win_uop[i];
				r.rs_val = i_rs_val[i];
				r.rt_val = i_rt_val[i];
			end
		end
		return r;
	endfunction

	always_comb begin
		for (int i = 0; i < DEPTH; i++) begin
			src_mask[i] = '0;
			dst_mask[i] = '0;
			if (win_uop[i].uses_rs)
				src_mask[i][win_uop[i].rs] = 1'b1;
			if (win_uop[i].uses_rt)
				src_mask[i][win_uop[i].rt] = 1'b1;
			if (win_uop[i].writes_rd)
				dst_mask[i][win_uop[i].rd] = 1'b1;
			o_rs_idx[i] = win_uop[i].rs;
			o_rt_idx[i] = win_uop[i].rt;
		end
	end

	// older entries still count while they issue this cycle
	always_comb begin
		older_wr = '0;
		older_rd = '0;
		older_mem = 1'b0;
		for (int i = 0; i < DEPTH; i++) begin
			ready[i] = win_v[i]
				&& (((src_mask[i] | dst_mask[i]) & (pending | older_wr)) == '0)
				&& ((dst_mask[i] & older_rd) == '0);
			mem_first[i] = !older_mem;
			if (win_v[i]) begin
				older_wr = older_wr | dst_mask[i];
				older_rd = older_rd | src_mask[i];
				if (win_uop[i].unit == core_pkg::UNIT_MEM)
					older_mem = 1'b1;
			end
		end
	end

	// walk from the youngest so the oldest eligible entry wins
	always_comb begin
		alu_sel = '0;
		mem_sel = '0;
		for (int i = DEPTH - 1; i >= 0; i--) begin
			if (ready[i] && win_uop[i].unit == core_pkg::UNIT_ALU)
				alu_sel = DEPTH'(1) << i;
			if (ready[i] && mem_first[i] && win_uop[i].unit == core_pkg::UNIT_MEM)
				mem_sel = DEPTH'(1) << i;
		end
	end

	assign remain = win_v & ~(alu_sel | mem_sel);
	assign o_busy = $countones(remain) >= 2;

	always_comb begin
		alu_nxt = pick(alu_sel);
		mem_nxt = pick(mem_sel);
		set_mask = '0;
		for (int i = 0; i < DEPTH; i++) begin
			if (alu_sel[i] || mem_sel[i])
				set_mask = set_mask | dst_mask[i];
		end
		clr_mask = '0;
		if (i_alu_wb.valid)
			clr_mask[i_alu_wb.rd] = 1'b1;
		if (i_mem_wb.valid)
			clr_mask[i_mem_wb.rd] = 1'b1;
	end

	// compact toward entry 0, decoded ops only enter when not busy
	always_comb begin
		nxt_v = '0;
		fill = '0;
		for (int i = 0; i < DEPTH; i++)
			nxt_uop[i] = win_uop[i];
		for (int i = 0; i < DEPTH; i++) begin
			if (remain[i]) begin
				nxt_uop[fill] = win_uop[i];
				nxt_v[fill] = 1'b1;
				fill = fill + 2'd1;
			end
		end
		if (!o_busy) begin
			if (i_valid0) begin
				nxt_uop[fill] = i_uop0;
				nxt_v[fill] = 1'b1;
				fill = fill + 2'd1;
			end
			if (i_valid1) begin
				nxt_uop[fill] = i_uop1;
				nxt_v[fill] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			win_v <= '0;
			pending <= '0;
			o_alu_issue.valid <= 1'b0;
			o_mem_issue.valid <= 1'b0;
		end else begin
			win_v <= nxt_v;
			pending <= (pending & ~clr_mask) | set_mask;
			o_alu_issue <= alu_nxt;
			o_mem_issue <= mem_nxt;
		end
	end

	always_ff @(posedge clk) begin
		win_uop <= nxt_uop;
	end

endmodule

// File: rtl/mem_unit.sv
`timescale 1ns/1ps
`include "core_config.svh"

module mem_unit (
	input  logic                      clk,
	input  logic                      rstn,
	input  core_pkg::issue_t          i_issue,
	input  logic [`CORE_XLEN-1:0]     i_drdata,
	output logic [`CORE_DADDR_W-1:0]  o_daddr,
	output logic [`CORE_XLEN-1:0]     o_dwdata,
	output logic                      o_den,
	output logic                      o_dwe,
	output core_pkg::wb_t             o_wb
);

	logic [`CORE_XLEN-1:0] addr;
	logic ld_valid;
	logic [`CORE_REG_W-1:0] ld_rd;

	// word address, upper bits of the sum dropped
	assign addr = i_issue.rs_val + i_issue.uop.imm;

	always_ff @(posedge clk) begin
		o_daddr <= addr[`CORE_DADDR_W-1:0];
		o_dwdata <= i_issue.rt_val;
		ld_rd <= i_issue.uop.rd;
		// read data lands the cycle after o_den
		o_wb.rd <= ld_rd;
		o_wb.data <= i_drdata;
		if (!rstn) begin
			o_den <= 1'b0;
			o_dwe <= 1'b0;
			ld_valid <= 1'b0;
			o_wb.valid <= 1'b0;
		end else begin
			o_den <= i_issue.valid;
			o_dwe <= i_issue.valid && i_issue.uop.op == isa_pkg::OP_SW;
			ld_valid <= i_issue.valid && i_issue.uop.op == isa_pkg::OP_LW
				&& i_issue.uop.writes_rd;
			o_wb.valid <= ld_valid;
		end
	end

endmodule

// File: rtl/reg_file.sv
`timescale 1ns/1ps
`include "core_config.svh"

module reg_file (
	input  logic                                         clk,
	input  logic                                         rstn,
	input  logic [`CORE_WIN_DEPTH-1:0][`CORE_REG_W-1:0]  i_rs_idx,
	input  logic [`CORE_WIN_DEPTH-1:0][`CORE_REG_W-1:0]  i_rt_idx,
	input  core_pkg::wb_t                                i_alu_wb,
	input  core_pkg::wb_t                                i_mem_wb,
	output logic [`CORE_WIN_DEPTH-1:0][`CORE_XLEN-1:0]   o_rs_val,
	output logic [`CORE_WIN_DEPTH-1:0][`CORE_XLEN-1:0]   o_rt_val
);

	logic [`CORE_XLEN-1:0] regs [`CORE_NREG];
	core_pkg::wb_t alu_q;
	core_pkg::wb_t mem_q;

	// writebacks waiting for the array take priority over it
	function automatic logic [`CORE_XLEN-1:0] read_port(input logic [`CORE_REG_W-1:0] idx);
		if (idx == '0)
			return '0;
		if (alu_q.valid && alu_q.rd == idx)
			return alu_q.data;
		if (mem_q.valid && mem_q.rd == idx)
			return mem_q.data;
		return regs[idx];
	endfunction

	always_comb begin
		for (int i = 0; i < `CORE_WIN_DEPTH; i++) begin
			o_rs_val[i] = read_port(i_rs_idx[i]);
			o_rt_val[i] = read_port(i_rt_idx[i]);
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			alu_q.valid <= 1'b0;
			mem_q.valid <= 1'b0;
		end else begin
			alu_q <= i_alu_wb;
			mem_q <= i_mem_wb;
		end
	end

	always_ff @(posedge clk) begin
		if (alu_q.valid && alu_q.rd != '0)
			regs[alu_q.rd] <= alu_q.data;
		if (mem_q.valid && mem_q.rd != '0)
			regs[mem_q.rd] <= mem_q.data;
	end

endmodule

// File: tb/cpu_core_chk.sv
`timescale 1ns/1ps
`include "core_config.svh"

module cpu_core_chk (
	input logic                     clk,
	input logic                     rstn,
	input logic [`CORE_IADDR_W-1:0] i_iaddr,
	input logic                     i_den,
	input logic                     i_dwe
);

	localparam logic [`CORE_IADDR_W-1:0] ONE_WORD = 1;

	// rstn as seen at the last two edges
	logic [1:0] rst_hist;
	logic reset_err = 1'b0;
	logic dwe_err = 1'b0;
	logic iaddr_err = 1'b0;

	always_ff @(posedge clk) begin
		rst_hist <= {rst_hist[0], rstn};
	end

	// data port quiet through reset and the begin cycle
	a_reset_quiet: assert property (@(posedge clk)
		(rst_hist[0] === 1'b0 || rst_hist[1] === 1'b0) |-> (!i_den && !i_dwe))
	else begin
		reset_err = 1'b1;
		$error("data port active during reset or the begin cycle");
	end

	a_dwe_with_den: assert property (@(posedge clk) disable iff (!rstn)
		i_dwe |-> i_den)
	else begin
		dwe_err = 1'b1;
		$error("o_dwe high while o_den is low");
	end

	// fetch address holds or steps by one word
	a_iaddr_step: assert property (@(posedge clk) disable iff (!rstn)
		$past(rstn) |-> (i_iaddr == $past(i_iaddr)) || (i_iaddr == $past(i_iaddr) + ONE_WORD))
	else begin
		iaddr_err = 1'b1;
		$error("o_iaddr jumped by more than one word");
	end

endmodule

// File: tb/tb_cpu_core.sv
`timescale 1ns/1ps
`include "core_config.svh"

module tb_cpu_core;

	localparam int IMEM_WORDS = 1 << `CORE_IADDR_W;
	localparam int DMEM_WORDS = 1 << `CORE_DADDR_W;
	localparam int CYCLES_PER_INSTR = 40;

	logic clk;
	logic rstn;
	logic [`CORE_IADDR_W-1:0] iaddr;
	logic ien;
	logic [2*`CORE_XLEN-1:0] idata;
	logic [`CORE_DADDR_W-1:0] daddr;
	logic [`CORE_XLEN-1:0] dwdata;
	logic [`CORE_XLEN-1:0] drdata;
	logic den;
	logic dwe;

	logic [2*`CORE_XLEN-1:0] imem [IMEM_WORDS];
	logic [`CORE_XLEN-1:0] dmem [DMEM_WORDS];
	logic [`CORE_IADDR_W-1:0] iaddr_q;
	logic [31:0] prog [$];
	logic [`CORE_DADDR_W-1:0] exp_addr [$];
	logic [`CORE_XLEN-1:0] exp_data [$];
	int exp_total;
	int stores_seen = 0;
	int limit_cycles = 0;
	integer seed;

	cpu_core UUT (
		.clk      (clk),
		.rstn     (rstn),
		.o_iaddr  (iaddr),
		.o_ien    (ien),
		.i_idata  (idata),
		.o_daddr  (daddr),
		.o_dwdata (dwdata),
		.i_drdata (drdata),
		.o_den    (den),
		.o_dwe    (dwe)
	);

	bind cpu_core cpu_core_chk u_chk (
		.clk     (clk),
		.rstn    (rstn),
		.i_iaddr (o_iaddr),
		.i_den   (o_den),
		.i_dwe   (o_dwe)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic fail_run(input string why);
		$display("ERROR at %0t: %s", $time, why);
		$display("*** FAILED ***");
		$fatal(1, "run stopped");
	endtask

	task automatic put_r(input isa_pkg::op_e op, input int rd, input int rs, input int rt);
		prog.push_back({op, 5'(rd), 5'(rs), 5'(rt), 11'd0});
	endtask

	task automatic put_i(input isa_pkg::op_e op, input int rd, input int rs, input int imm);
		prog.push_back({op, 5'(rd), 5'(rs), 16'(imm)});
	endtask

	// rt shares the top five bits of the store offset
	task automatic put_sw(input int rs, input int rt, input int off);
		prog.push_back({isa_pkg::OP_SW, 5'd0, 5'(rs), 5'(rt), 11'(off)});
	endtask

	task automatic build_program();
		put_i(isa_pkg::OP_ADDI, 1, 0, 5);
		put_i(isa_pkg::OP_ADDI, 2, 0, 7);
		put_i(isa_pkg::OP_ADDI, 3, 0, -3);
		put_i(isa_pkg::OP_ADDI, 4, 0, 'h100);
		// independent alu pairs
		put_r(isa_pkg::OP_ADD, 5, 1, 2);
		put_r(isa_pkg::OP_SUB, 6, 1, 2);
		put_r(isa_pkg::OP_AND, 7, 1, 3);
		put_r(isa_pkg::OP_OR, 8, 2, 3);
		put_sw(4, 5, 0);
		put_sw(4, 6, 1);
		put_sw(4, 7, 2);
		put_sw(4, 8, 3);
		put_r(isa_pkg::OP_NOP, 0, 0, 0);
		// back to back chain
		put_r(isa_pkg::OP_ADD, 9, 5, 6);
		put_r(isa_pkg::OP_ADD, 10, 9, 9);
		put_r(isa_pkg::OP_SUB, 11, 10, 1);
		put_sw(4, 9, 4);
		put_sw(4, 10, 5);
		put_sw(4, 11, 6);
		// load then use, from the preload and from the first stored word
		put_i(isa_pkg::OP_LW, 12, 4, 'h40);
		put_r(isa_pkg::OP_ADD, 13, 12, 1);
		put_sw(4, 12, 7);
		put_sw(4, 13, 8);
		put_i(isa_pkg::OP_LW, 14, 4, 5 << 11);
		put_i(isa_pkg::OP_ADDI, 15, 14, 1);
		put_sw(4, 14, 9);
		put_sw(4, 15, 10);
		// dependent burst to fill the window
		put_i(isa_pkg::OP_ADDI, 16, 1, 1);
		repeat (5)
			put_i(isa_pkg::OP_ADDI, 16, 16, 1);
		put_r(isa_pkg::OP_ADD, 17, 16, 2);
		put_i(isa_pkg::OP_ADDI, 16, 0, 9);
		put_r(isa_pkg::OP_OR, 18, 17, 16);
		put_sw(4, 16, 11);
		put_sw(4, 17, 12);
		put_sw(4, 18, 13);
		// r0 as target and as base
		put_i(isa_pkg::OP_ADDI, 0, 1, 3);
		put_r(isa_pkg::OP_ADD, 19, 0, 1);
		put_sw(4, 19, 14);
		put_sw(0, 19, 15);
		if (prog.size() % 2 != 0)
			put_r(isa_pkg::OP_NOP, 0, 0, 0);
	endtask

	// in-order interpreter of the program, collects the expected stores
	task automatic run_reference();
		logic [`CORE_XLEN-1:0] regs [`CORE_NREG];
		logic [`CORE_XLEN-1:0] written [int];
		logic [31:0] ins;
		logic [`CORE_XLEN-1:0] a;
		logic [`CORE_XLEN-1:0] b;
		logic [`CORE_XLEN-1:0] imm;
		logic [`CORE_XLEN-1:0] ea;
		logic [`CORE_XLEN-1:0] res;
		logic [`CORE_DADDR_W-1:0] addr;
		logic wr;
		for (int r = 0; r < `CORE_NREG; r++)
			regs[r] = '0;
		foreach (prog[i]) begin
			ins = prog[i];
			a = regs[ins[20:16]];
			b = regs[ins[15:11]];
			imm = {{16{ins[15]}}, ins[15:0]};
			ea = a + imm;
			addr = ea[`CORE_DADDR_W-1:0];
			res = '0;
			wr = 1'b1;
			case (ins[31:26])
				isa_pkg::OP_ADD:  res = a + b;
				isa_pkg::OP_SUB:  res = a - b;
				isa_pkg::OP_AND:  res = a & b;
				isa_pkg::OP_OR:   res = a | b;
				isa_pkg::OP_ADDI: res = ea;
				isa_pkg::OP_LW:   res = written.exists(addr) ? written[addr] : dmem[addr];
				isa_pkg::OP_SW: begin
					written[addr] = b;
					exp_addr.push_back(addr);
					exp_data.push_back(b);
					wr = 1'b0;
				end
				default: wr = 1'b0;
			endcase
			if (wr && ins[25:21] != 5'd0)
				regs[ins[25:21]] = res;
		end
		exp_total = exp_addr.size();
	endtask

	task automatic check_store(input logic [`CORE_DADDR_W-1:0] addr,
			input logic [`CORE_XLEN-1:0] data);
		logic [`CORE_DADDR_W-1:0] want_addr;
		logic [`CORE_XLEN-1:0] want_data;
		assert (exp_addr.size() != 0)
		else fail_run("store seen after the last expected store");
		want_addr = exp_addr.pop_front();
		want_data = exp_data.pop_front();
		assert (addr == want_addr)
		else begin
			$display("CHECK FAILED at %0t: o_daddr expected %h got %h", $time, want_addr, addr);
			fail_run("store address mismatch");
		end
		assert (data == want_data)
		else begin
			$display("CHECK FAILED at %0t: o_dwdata expected %h got %h", $time, want_data, data);
			fail_run("store data mismatch");
		end
		stores_seen++;
	endtask

	// instruction memory, one cycle read latency
	always @(posedge clk) begin
		iaddr_q <= iaddr;
	end

	always @(negedge clk) begin
		idata <= imem[iaddr_q];
	end

	// data memory and store checker
	always @(negedge clk) begin
		if (rstn && den) begin
			if (dwe) begin
				check_store(daddr, dwdata);
				dmem[daddr] <= dwdata;
			end else begin
				drdata <= dmem[daddr];
			end
		end
	end

	// instruction memory is read every cycle
	always @(negedge clk) begin
		assert (ien === 1'b1)
		else begin
			$display("CHECK FAILED at %0t: o_ien expected 1 got %b", $time, ien);
			fail_run("instruction enable not high");
		end
	end

	always @(negedge clk) begin
		assert (!(UUT.u_chk.reset_err || UUT.u_chk.dwe_err || UUT.u_chk.iaddr_err))
		else fail_run("a port assertion in cpu_core_chk failed");
	end

	initial begin
		rstn = 1'b0;
		idata = '0;
		drdata = '0;
		seed = 78;
		for (int i = 0; i < IMEM_WORDS; i++)
			imem[i] = '0;
		for (int i = 0; i < DMEM_WORDS; i++)
			dmem[i] = $random(seed);
		build_program();
		// first instruction of a pair sits in the upper half
		for (int i = 0; i < prog.size(); i += 2)
			imem[i / 2] = {prog[i], prog[i + 1]};
		run_reference();
		limit_cycles = CYCLES_PER_INSTR * prog.size();
		repeat (4) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1;
		wait (stores_seen == exp_total);
		// drain, a stray store would still show up here
		repeat (20) @(posedge clk);
		if (stores_seen == exp_total && exp_addr.size() == 0) begin
			$display("*** PASSED ***");
			$finish;
		end else begin
			fail_run("store count differs from the reference");
		end
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		fail_run($sformatf("watchdog expired with %0d of %0d stores seen",
			stores_seen, exp_total));
	end

endmodule
